// ==== dbg_unit.f ====
+incdir+.
dbg_unit_pkg.sv
dbg_cmd_decode.sv
dbg_prog_loader.sv
dbg_run_control.sv
dbg_state_dump.sv
dbg_unit.sv
dbg_unit_assert.sv
dbg_unit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the dbg_unit testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --assert --timing -Wno-fatal \
  --timescale 1ns/1ps \
  --top-module dbg_unit_tb \
  -f dbg_unit.f \
  -o dbg_unit_sim

./obj_dir/dbg_unit_sim 2>&1 | tee "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
  echo "simulation reported a failure"
  exit 1
fi
echo "simulation finished without failure"

// ==== dbg_unit_tb.sv ====
`default_nettype none

`include "dbg_unit_defines.svh"

module dbg_unit_tb
  import dbg_unit_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_HALF       = 10;
  localparam int TIMEOUT_CYCLES = 4000;  // full run needs well under 1500

  logic                   clk;
  logic                   reset;
  logic                   rx_valid;
  logic [`DBG_BYTE_W-1:0] rx_data;
  logic                   tx_ready;
  logic                   halt;
  logic [`DBG_WORD_W-1:0] bucket;
  logic                   tx_valid;
  logic [`DBG_BYTE_W-1:0] tx_data;
  logic                   imem_we;
  logic [`DBG_ADDR_W-1:0] imem_addr;
  logic [`DBG_WORD_W-1:0] imem_data;
  logic                   cpu_clk_en;
  logic                   debug;

  int                     seed = 72698;
  int                     cycles = 0;
  int                     en_count;   // cycles with cpu_clk_en high
  logic [`DBG_ADDR_W-1:0] next_addr;  // address of the next expected write

  // expected traffic
  logic [`DBG_ADDR_W-1:0] wr_addr_q[$];
  logic [`DBG_WORD_W-1:0] wr_data_q[$];
  logic [`DBG_BYTE_W-1:0] tx_byte_q[$];

  dbg_unit dbg_unit_inst (.*);  // port names match one to one

  initial clk = 1'b0;
  always #CLK_HALF clk = ~clk;

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic stop_with_failure();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    assert (actual === expected)
    else
    begin
      $display("Error: %s expected %h got %h", name, expected, actual);
      stop_with_failure();
    end
  endtask

  // one host byte, then two idle cycles
  task automatic send_byte(input logic [`DBG_BYTE_W-1:0] value);
    rx_valid <= 1'b1;
    rx_data  <= value;
    @(posedge clk);
    rx_valid <= 1'b0;
    repeat (2) @(posedge clk);
  endtask

  task automatic start_load();
    next_addr = '0;  // every start loads from zero
    send_byte(`DBG_CMD_START);
  endtask

  // four bytes lowest first, one write expected
  task automatic load_word(input logic [`DBG_WORD_W-1:0] word);
    prog_word_u w;
    w = word;
    wr_addr_q.push_back(next_addr);
    wr_data_q.push_back(word);
    next_addr = next_addr + 1'b1;
    for (int i = 0; i < `DBG_WORD_W / `DBG_BYTE_W; i++)
    begin
      check_eq("debug", 32'd1, 32'(debug));
      send_byte(w.bytes[i]);
    end
    if (w.fields.opcode == `DBG_END_OPCODE)
    begin
      @(posedge clk);
      check_eq("debug", 32'd0, 32'(debug));  // program closed
    end
  endtask

  task automatic set_bucket(input logic [`DBG_WORD_W-1:0] value);
    bucket <= value;
    for (int i = 0; i < `DBG_BUCKET_BYTES; i++)
      tx_byte_q.push_back(value[i*`DBG_BYTE_W +: `DBG_BYTE_W]);
  endtask

  task automatic wait_dump_end();
    while (tx_byte_q.size() != 0)
      @(posedge clk);
    repeat (3) @(posedge clk);  // done pulse and mode change
    check_eq("tx_valid", 32'd0, 32'(tx_valid));
  endtask

  //////////////////////////////////////////////////
  // monitors, random ready, timeout
  //////////////////////////////////////////////////

  always @(posedge clk)
  begin
    if (!reset && imem_we)
    begin
      if (wr_addr_q.size() == 0)
      begin
        $display("unexpected instruction memory write at address %h", imem_addr);
        stop_with_failure();
      end
      else
      begin
        check_eq("imem_addr", 32'(wr_addr_q.pop_front()), 32'(imem_addr));
        check_eq("imem_data", wr_data_q.pop_front(), imem_data);
        check_eq("debug", 32'd1, 32'(debug));
      end
    end
  end

  always @(posedge clk)
  begin
    if (!reset && tx_valid && tx_ready)
    begin
      if (tx_byte_q.size() == 0)
      begin
        $display("unexpected byte %h sent to the host", tx_data);
        stop_with_failure();
      end
      else
        check_eq("tx_data", 32'(tx_byte_q.pop_front()), 32'(tx_data));
    end
  end

  always @(posedge clk)
  begin
    if (reset)
      en_count <= 0;
    else if (cpu_clk_en)
      en_count <= en_count + 1;
  end

  always @(posedge clk)
    tx_ready <= ($random(seed) & 1) != 0;

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("run timed out after %0d cycles", cycles);
      stop_with_failure();
    end
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial
  begin
    int en_before;
    reset     = 1'b1;
    rx_valid  = 1'b0;
    rx_data   = '0;
    tx_ready  = 1'b0;
    halt      = 1'b0;
    bucket    = '0;
    next_addr = '0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    // idle ignores everything but start
    send_byte(`DBG_CMD_CONT);
    send_byte(8'h5a);
    send_byte(`DBG_CMD_STEP);
    check_eq("debug", 32'd0, 32'(debug));

    start_load();
    load_word(32'h1234_5678);
    load_word(32'h0bad_f00d);
    load_word(32'h8000_0001);
    load_word(32'hfc00_002a);  // end opcode

    // stray bytes, waiting drops back to idle
    send_byte(8'h55);
    send_byte(8'h44);
    check_eq("debug", 32'd0, 32'(debug));

    start_load();
    load_word(32'h2040_6080);
    load_word(32'hdead_beef);
    load_word(32'hffff_ffff);

    // single step, a second step lands inside the dump
    send_byte(`DBG_CMD_STEPMODE);
    en_before = en_count;
    set_bucket(32'ha5c3_0f01);
    send_byte(`DBG_CMD_STEP);
    while (!tx_valid)
      @(posedge clk);
    send_byte(`DBG_CMD_STEP);
    wait_dump_end();
    check_eq("cpu_clk_en cycles", en_before + 1, en_count);

    // last step with halt high returns to waiting
    halt <= 1'b1;
    en_before = en_count;
    set_bucket(32'h7e81_3c42);
    send_byte(`DBG_CMD_STEP);
    wait_dump_end();
    check_eq("cpu_clk_en cycles", en_before + 1, en_count);

    halt <= 1'b0;
    set_bucket(32'h0f1e_2d3c);
    send_byte(`DBG_CMD_CONT);
    repeat (12)
    begin
      check_eq("cpu_clk_en", 32'd1, 32'(cpu_clk_en));
      @(posedge clk);
    end
    halt <= 1'b1;
    @(posedge clk);
    check_eq("cpu_clk_en", 32'd1, 32'(cpu_clk_en));  // halt not seen yet
    @(posedge clk);
    check_eq("cpu_clk_en", 32'd0, 32'(cpu_clk_en));
    wait_dump_end();

    // reprogram, new load starts at zero again
    halt <= 1'b0;
    send_byte(`DBG_CMD_REPROG);
    check_eq("debug", 32'd0, 32'(debug));
    start_load();
    load_word(32'h0000_0011);
    load_word(32'hfc12_3456);
    repeat (4) @(posedge clk);

    if (wr_addr_q.size() != 0 || tx_byte_q.size() != 0)
    begin
      $display("run ended with %0d writes and %0d bytes never seen",
               wr_addr_q.size(), tx_byte_q.size());
      stop_with_failure();
    end
    else
    begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== dbg_unit_assert.sv ====
`default_nettype none

`include "dbg_unit_defines.svh"

module dbg_unit_assert
  import dbg_unit_pkg::*;
(
  input logic                   clk,
  input logic                   reset,
  input logic                   imem_we,
  input logic                   cpu_clk_en,
  input logic                   debug,
  input logic                   tx_valid,
  input logic                   tx_ready,
  input logic [`DBG_BYTE_W-1:0] tx_data,
  input logic                   halt,
  input logic                   cmd_valid,
  input dbg_cmd_e               cmd,
  input logic                   dump_start
);

  timeunit 1ns;
  timeprecision 1ps;

  //////////////////////////////////////////////////
  // reset and idle
  //////////////////////////////////////////////////

  quiet_after_reset: assert property (@(posedge clk)
    reset |=> !imem_we && !cpu_clk_en && !debug && !tx_valid)
    else $error("outputs active right after reset");

  // only a start command opens loading
  debug_needs_start: assert property (@(posedge clk) disable iff (reset)
    $rose(debug) |-> $past(cmd_valid && (cmd == CMD_START)))
    else $error("debug rose without a start command");

  //////////////////////////////////////////////////
  // processor enable
  //////////////////////////////////////////////////

  step_one_cycle: assert property (@(posedge clk) disable iff (reset)
    $rose(cpu_clk_en) && $past(cmd_valid && (cmd == CMD_STEP)) |=> !cpu_clk_en)
    else $error("step enable longer than one cycle");

  step_ignored_in_dump: assert property (@(posedge clk) disable iff (reset)
    cmd_valid && (cmd == CMD_STEP) && tx_valid |=> !cpu_clk_en)
    else $error("step during a dump raised the enable");

  halt_stops_run: assert property (@(posedge clk) disable iff (reset)
    halt && cpu_clk_en |=> !cpu_clk_en)
    else $error("enable still high after halt");

  // dump start comes with the fall or one cycle later
  dump_after_enable: assert property (@(posedge clk) disable iff (reset)
    $fell(cpu_clk_en) && !dump_start |=> dump_start)
    else $error("no state dump after the enable ended");

  // byte held under back-pressure
  tx_hold: assert property (@(posedge clk) disable iff (reset)
    tx_valid && !tx_ready |=> tx_valid && $stable(tx_data))
    else $error("tx byte changed while not accepted");

endmodule

bind dbg_unit dbg_unit_assert dbg_unit_assert_inst (
  .clk        (clk),
  .reset      (reset),
  .imem_we    (imem_we),
  .cpu_clk_en (cpu_clk_en),
  .debug      (debug),
  .tx_valid   (tx_valid),
  .tx_ready   (tx_ready),
  .tx_data    (tx_data),
  .halt       (halt),
  .cmd_valid  (cmd_valid),
  .cmd        (cmd),
  .dump_start (dump_start)
);

`default_nettype wire

// ==== dbg_unit.sv ====
`default_nettype none

`include "dbg_unit_defines.svh"

module dbg_unit
  import dbg_unit_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   rx_valid,
  input  logic [`DBG_BYTE_W-1:0] rx_data,
  input  logic                   tx_ready,
  input  logic                   halt,
  input  logic [`DBG_WORD_W-1:0] bucket,
  output logic                   tx_valid,
  output logic [`DBG_BYTE_W-1:0] tx_data,
  output logic                   imem_we,
  output logic [`DBG_ADDR_W-1:0] imem_addr,
  output logic [`DBG_WORD_W-1:0] imem_data,
  output logic                   cpu_clk_en,
  output logic                   debug
);

  logic                   cmd_valid;
  dbg_cmd_e               cmd;
  logic                   byte_valid;
  logic [`DBG_BYTE_W-1:0] byte_data;
  logic                   loading;
  logic                   load_start;
  logic                   load_done;
  logic                   dump_start;
  logic                   dump_done;

  dbg_cmd_decode dbg_cmd_decode_inst (
    .clk        (clk),
    .reset      (reset),
    .rx_valid   (rx_valid),
    .rx_data    (rx_data),
    .loading    (loading),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .byte_valid (byte_valid),
    .byte_data  (byte_data)
  );

  dbg_prog_loader dbg_prog_loader_inst (
    .clk        (clk),
    .reset      (reset),
    .load_start (load_start),
    .byte_valid (byte_valid),
    .byte_data  (byte_data),
    .imem_we    (imem_we),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .load_done  (load_done)
  );

  dbg_run_control dbg_run_control_inst (
    .clk        (clk),
    .reset      (reset),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .load_done  (load_done),
    .dump_done  (dump_done),
    .halt       (halt),
    .loading    (loading),
    .load_start (load_start),
    .debug      (debug),
    .cpu_clk_en (cpu_clk_en),
    .dump_start (dump_start)
  );

  dbg_state_dump dbg_state_dump_inst (
    .clk        (clk),
    .reset      (reset),
    .dump_start (dump_start),
    .bucket     (bucket),
    .tx_ready   (tx_ready),
    .tx_valid   (tx_valid),
    .tx_data    (tx_data),
    .dump_done  (dump_done)
  );

endmodule

`default_nettype wire

// ==== dbg_state_dump.sv ====
`default_nettype none

`include "dbg_unit_defines.svh"

module dbg_state_dump (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   dump_start,
  input  logic [`DBG_WORD_W-1:0] bucket,
  input  logic                   tx_ready,
  output logic                   tx_valid,
  output logic [`DBG_BYTE_W-1:0] tx_data,
  output logic                   dump_done
);

  localparam int IDX_W = $clog2(`DBG_BUCKET_BYTES);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`DBG_BUCKET_BYTES - 1);

  logic [`DBG_BUCKET_BYTES-1:0][`DBG_BYTE_W-1:0] bucket_q;  // snapshot
  logic [IDX_W-1:0] idx;
  logic [IDX_W-1:0] idx_next;
  logic             accept;

  assign accept   = tx_valid && tx_ready;
  assign idx_next = idx + 1'b1;

  // handshake state
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      tx_valid  <= 1'b0;
      idx       <= '0;
      dump_done <= 1'b0;
    end
    else
    begin
      dump_done <= 1'b0;
      if (dump_start)
      begin
        tx_valid <= 1'b1;
        idx      <= '0;
      end
      else if (accept)
      begin
        if (idx == LAST_IDX)
        begin
          tx_valid  <= 1'b0;
          dump_done <= 1'b1;  // last byte taken
        end
        else
          idx <= idx_next;
      end
    end
  end

  // payload, held while tx_ready is low
  always_ff @(posedge clk)
  begin
    if (dump_start)
    begin
      bucket_q <= bucket;
      tx_data  <= bucket[`DBG_BYTE_W-1:0];  // lowest byte first
    end
    else if (accept && (idx != LAST_IDX))
      tx_data <= bucket_q[idx_next];
  end

endmodule

`default_nettype wire

// ==== dbg_run_control.sv ====
`default_nettype none

module dbg_run_control
  import dbg_unit_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     cmd_valid,
  input  dbg_cmd_e cmd,
  input  logic     load_done,
  input  logic     dump_done,
  input  logic     halt,
  output logic     loading,
  output logic     load_start,
  output logic     debug,
  output logic     cpu_clk_en,
  output logic     dump_start
);

  dbg_mode_e mode;
  dbg_mode_e mode_next;
  logic      step_cmd;
  logic      dump_req;  // dump entered, start goes out next cycle

  assign step_cmd = cmd_valid && (cmd == CMD_STEP);

  //////////////////////////////////////////////////
  // next mode
  //////////////////////////////////////////////////

  always_comb
  begin
    mode_next = mode;
    case (mode)
      IDLE:
        if (cmd_valid && (cmd == CMD_START))
          mode_next = LOADING;
      LOADING:
        if (load_done)
          mode_next = WAITING;
      WAITING:
        if (cmd_valid)
        begin
          case (cmd)
            CMD_CONT:     mode_next = RUNNING;
            CMD_STEPMODE: mode_next = STEPPING;
            CMD_REPROG:   mode_next = IDLE;
            default:      mode_next = IDLE;  // unexpected command
          endcase
        end
      STEPPING:
        if (step_cmd)
          mode_next = DUMPING;
      RUNNING:
        if (halt)
          mode_next = DUMPING;
      DUMPING:
        if (dump_done)
          mode_next = halt ? WAITING : STEPPING;
      default:
        mode_next = IDLE;
    endcase
  end

  //////////////////////////////////////////////////
  // mode register and outputs
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      mode       <= IDLE;
      loading    <= 1'b0;
      load_start <= 1'b0;
      cpu_clk_en <= 1'b0;
      dump_req   <= 1'b0;
      dump_start <= 1'b0;
    end
    else
    begin
      mode       <= mode_next;
      loading    <= (mode_next == LOADING);
      load_start <= (mode == IDLE) && (mode_next == LOADING);
      // run holds enable, a step gives one cycle
      cpu_clk_en <= (mode_next == RUNNING) || ((mode == STEPPING) && step_cmd);
      dump_req   <= (mode_next == DUMPING) && (mode != DUMPING);
      dump_start <= dump_req;  // bucket is settled by now
    end
  end

  assign debug = loading;

endmodule

`default_nettype wire

// ==== dbg_prog_loader.sv ====
`default_nettype none

`include "dbg_unit_defines.svh"

module dbg_prog_loader
  import dbg_unit_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   load_start,
  input  logic                   byte_valid,
  input  logic [`DBG_BYTE_W-1:0] byte_data,
  output logic                   imem_we,
  output logic [`DBG_ADDR_W-1:0] imem_addr,
  output logic [`DBG_WORD_W-1:0] imem_data,
  output logic                   load_done
);

  prog_word_u word_q;     // partial word so far
  prog_word_u word_next;  // word including the current byte
  logic [1:0] byte_cnt;
  logic       last_byte;

  //////////////////////////////////////////////////
  // word assembly, lowest byte first
  //////////////////////////////////////////////////

  always_comb
  begin
    word_next                = word_q;
    word_next.bytes[byte_cnt] = byte_data;
  end

  assign last_byte = byte_valid && (byte_cnt == 2'd3);

  always_ff @(posedge clk)
  begin
    if (byte_valid)
      word_q <= word_next;
    if (last_byte)
      imem_data <= word_next;  // full word, held for the write
  end

  //////////////////////////////////////////////////
  // counter, address and write strobe
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      byte_cnt  <= 2'd0;
      imem_addr <= '0;
      imem_we   <= 1'b0;
      load_done <= 1'b0;
    end
    else if (load_start)
    begin
      // new program starts at address zero
      byte_cnt  <= 2'd0;
      imem_addr <= '0;
      imem_we   <= 1'b0;
      load_done <= 1'b0;
    end
    else
    begin
      imem_we   <= last_byte;
      load_done <= last_byte && (word_next.fields.opcode == `DBG_END_OPCODE);
      if (byte_valid)
        byte_cnt <= byte_cnt + 2'd1;  // wraps after the fourth byte
      if (imem_we)
        imem_addr <= imem_addr + 1'b1;  // bump once the write is done
    end
  end

endmodule

`default_nettype wire

// ==== dbg_cmd_decode.sv ====
`default_nettype none

`include "dbg_unit_defines.svh"

module dbg_cmd_decode
  import dbg_unit_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   rx_valid,
  input  logic [`DBG_BYTE_W-1:0] rx_data,
  input  logic                   loading,
  output logic                   cmd_valid,
  output dbg_cmd_e               cmd,
  output logic                   byte_valid,
  output logic [`DBG_BYTE_W-1:0] byte_data
);

  dbg_cmd_e cmd_next;

  // byte value to command
  always_comb
  begin
    case (rx_data)
      `DBG_CMD_START:    cmd_next = CMD_START;
      `DBG_CMD_CONT:     cmd_next = CMD_CONT;
      `DBG_CMD_STEPMODE: cmd_next = CMD_STEPMODE;
      `DBG_CMD_REPROG:   cmd_next = CMD_REPROG;
      `DBG_CMD_STEP:     cmd_next = CMD_STEP;
      default:           cmd_next = CMD_OTHER;
    endcase
  end

  // strobes, routed by loading
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      cmd_valid  <= 1'b0;
      byte_valid <= 1'b0;
    end
    else
    begin
      cmd_valid  <= rx_valid && !loading;
      byte_valid <= rx_valid && loading;  // program bytes go to the loader
    end
  end

  always_ff @(posedge clk)
  begin
    if (rx_valid)
    begin
      cmd       <= cmd_next;
      byte_data <= rx_data;
    end
  end

endmodule

`default_nettype wire

// ==== dbg_unit_pkg.sv ====
`default_nettype none

`include "dbg_unit_defines.svh"

package dbg_unit_pkg;

  // top level modes of the debug unit
  typedef enum logic [2:0] {
    IDLE,
    LOADING,
    WAITING,
    STEPPING,
    RUNNING,
    DUMPING
  } dbg_mode_e;

  // decoded host commands
  typedef enum logic [2:0] {
    CMD_START,
    CMD_CONT,
    CMD_STEPMODE,
    CMD_REPROG,
    CMD_STEP,
    CMD_OTHER     // anything not recognized
  } dbg_cmd_e;

  // one program word, seen as received bytes or as instruction fields
  typedef union packed {
    logic [`DBG_WORD_W/`DBG_BYTE_W-1:0][`DBG_BYTE_W-1:0] bytes;  // bytes[0] arrives first
    struct packed {
      logic [`DBG_OPCODE_W-1:0]             opcode;
      logic [`DBG_WORD_W-`DBG_OPCODE_W-1:0] rest;
    } fields;
  } prog_word_u;

endpackage

`default_nettype wire

// ==== dbg_unit_defines.svh ====
`ifndef DBG_UNIT_DEFINES_SVH
`define DBG_UNIT_DEFINES_SVH

//////////////////////////////////////////////////
// widths
//////////////////////////////////////////////////

`define DBG_BYTE_W        8    // serial link byte
`define DBG_WORD_W        32   // one instruction
`define DBG_ADDR_W        7    // instruction memory depth 128
`define DBG_BUCKET_BYTES  4    // bytes sent per state dump
`define DBG_OPCODE_W      6

//////////////////////////////////////////////////
// host command bytes
//////////////////////////////////////////////////

`define DBG_CMD_START     8'd1
`define DBG_CMD_CONT      8'd2
`define DBG_CMD_STEPMODE  8'd3
`define DBG_CMD_REPROG    8'd5
`define DBG_CMD_STEP      8'd6

// opcode that marks the last program word
`define DBG_END_OPCODE    6'b111111

`endif
